// File: logic/soc_bus_settings.svh
`ifndef SOC_BUS_SETTINGS_SVH
`define SOC_BUS_SETTINGS_SVH

// ----------------------------------------------------------------------
// Memory map of the slave fabric
// ----------------------------------------------------------------------

// Internal RAM, 8 KB echoed over the top 64 KB
`define RAM_BASE            32'hFFFF0000

// Video RAM, write-only character port
`define VRAM_BASE           32'h08000000
`define VRAM_LIMIT          32'h08004000

// GPIO register block
`define GPIO_BASE           32'h03000000
`define GPIO_LIMIT          32'h03000100

`define RAM_WORDS           2048        // 32-bit words in the internal RAM

// ----------------------------------------------------------------------
// GPIO register indices, taken from address bits 5:2
// ----------------------------------------------------------------------

`define GPIO_REG_DELAY      4'd0        // R: detected delay, W: delay select
`define GPIO_REG_LED        4'd1        // Bit 0 red, bit 1 green, bit 2 blue
`define GPIO_REG_Z80_RST    4'd3
`define GPIO_REG_I2C_SCL    4'd5
`define GPIO_REG_I2C_SDA    4'd6        // Write 0 pulls the line low
`define GPIO_REG_USB_RST    4'd7        // Active low USB reset

// GPIO values loaded by reset, delay select copies the detected value
`define GPIO_RST_LED        1'b0
`define GPIO_RST_Z80_RST    1'b1        // Coprocessor held in reset
`define GPIO_RST_I2C_SCL    1'b1
`define GPIO_RST_I2C_SDA_OE 1'b0        // Line released
`define GPIO_RST_USB_RSTN   1'b0

// Read data for write-only and unmapped regions
`define BUS_UNMAPPED_DATA   32'hFFFFFFFF

`endif

// File: logic/soc_bus_pkg.sv
package soc_bus_pkg;

    // ----------------------------------------------------------------------
    // Plain vector types
    // ----------------------------------------------------------------------

    typedef logic [31:0] bus_addr_t;     // Byte address
    typedef logic [31:0] bus_data_t;
    typedef logic [3:0]  bus_strb_t;     // All zero is a read
    typedef logic [10:0] ram_index_t;    // Word index into the internal RAM
    typedef logic [11:0] vram_index_t;   // Character cell index
    typedef logic [4:0]  delay_sel_t;    // Memory interface delay tap

    // ----------------------------------------------------------------------
    // Bundles
    // ----------------------------------------------------------------------

    // Request as driven by the CPU master
    typedef struct packed {
        logic      valid;
        bus_addr_t addr;
        bus_data_t wdata;
        bus_strb_t strb;
    } bus_req_t;

    // Registered region hits, none set means unmapped
    typedef struct packed {
        logic ram;
        logic vram;
        logic gpio;
    } region_sel_t;

    // Qualified access strobes
    typedef struct packed {
        logic ram_acc;     // Valid, not yet ready, in RAM
        logic vram_acc;    // Valid, not yet ready, in video RAM
        logic gpio_acc;    // Valid, in GPIO
        logic pending;     // Valid, not yet ready
        logic bad_access;  // First cycle of an access to an unmapped address
    } access_t;

    // Character write leaving the fabric
    typedef struct packed {
        logic        wr_en;
        vram_index_t index;
        logic [7:0]  char_data;
    } vram_wr_t;

    typedef struct packed {
        delay_sel_t delay_sel;
        logic       led_red;
        logic       led_green;
        logic       led_blue;
        logic       z80_rst;
        logic       i2c_scl;
        logic       i2c_sda_oe;  // 1 pulls SDA low
        logic       usb_rstn;
    } gpio_out_t;

endpackage

// File: logic/bus_region_decode.sv
`include "soc_bus_settings.svh"

module bus_region_decode (
    input  logic                    clk_rv,
    input  logic                    rst_rv,
    input  soc_bus_pkg::bus_addr_t  la_addr,
    input  soc_bus_pkg::bus_req_t   req,
    input  logic                    ready,
    output soc_bus_pkg::region_sel_t sel,
    output soc_bus_pkg::access_t    acc
);

    import soc_bus_pkg::*;

    logic la_in_ram;
    logic la_in_vram;
    logic la_in_gpio;
    logic valid_last;
    logic any_hit;

    // ----------------------------------------------------------------------
    // Look-ahead compares, one cycle ahead of valid
    // ----------------------------------------------------------------------

    assign la_in_ram  = (la_addr >= `RAM_BASE);   // Window runs to the top
    assign la_in_vram = (la_addr >= `VRAM_BASE) && (la_addr < `VRAM_LIMIT);
    assign la_in_gpio = (la_addr >= `GPIO_BASE) && (la_addr < `GPIO_LIMIT);

    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            sel        <= '0;
            valid_last <= 1'b0;
        end else begin
            sel.ram    <= la_in_ram;
            sel.vram   <= la_in_vram;
            sel.gpio   <= la_in_gpio;
            valid_last <= req.valid;      // For the rising edge of valid
        end
    end

    // ----------------------------------------------------------------------
    // Access strobes
    // ----------------------------------------------------------------------

    assign any_hit = sel.ram || sel.vram || sel.gpio;

    always_comb begin
        acc.pending    = req.valid && !ready;
        acc.ram_acc    = acc.pending && sel.ram;
        acc.vram_acc   = acc.pending && sel.vram;
        // GPIO stays selected through the ready cycle
        acc.gpio_acc   = req.valid && sel.gpio;
        acc.bad_access = req.valid && !valid_last && !any_hit;
    end

endmodule

// File: logic/onchip_mem_targets.sv
`include "soc_bus_settings.svh"

module onchip_mem_targets (
    input  logic                   clk_rv,
    input  soc_bus_pkg::bus_req_t  req,
    input  soc_bus_pkg::access_t   acc,
    output soc_bus_pkg::bus_data_t ram_rdata,
    output soc_bus_pkg::vram_wr_t  vram_wr
);

    import soc_bus_pkg::*;

    localparam int LANES = $bits(bus_strb_t);

    bus_data_t   mem [`RAM_WORDS];
    ram_index_t  ram_idx;
    vram_index_t vram_idx;

    // Upper address bits ignored, so the 8 KB array echoes over 64 KB
    assign ram_idx  = req.addr[12:2];
    assign vram_idx = req.addr[13:2];

    // ----------------------------------------------------------------------
    // Internal RAM with byte lanes
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_rv) begin
        if (acc.ram_acc) begin
            for (int lane = 0; lane < LANES; lane++) begin
                if (req.strb[lane]) begin
                    mem[ram_idx][lane*8 +: 8] <= req.wdata[lane*8 +: 8];
                end
            end
        end
        ram_rdata <= mem[ram_idx];        // Read every cycle, old data on a write
    end

    // ----------------------------------------------------------------------
    // Video RAM write port
    // ----------------------------------------------------------------------

    // vram_acc drops with ready, so the pulse lasts one cycle
    always_ff @(posedge clk_rv) begin
        vram_wr.wr_en     <= acc.vram_acc && (req.strb != '0);
        vram_wr.index     <= vram_idx;
        vram_wr.char_data <= req.wdata[7:0];   // Character in the low byte
    end

endmodule

// File: logic/gpio_regs.sv
`include "soc_bus_settings.svh"

module gpio_regs (
    input  logic                    clk_rv,
    input  logic                    rst_rv,
    input  soc_bus_pkg::bus_req_t   req,
    input  logic                    gpio_acc,
    input  soc_bus_pkg::delay_sel_t delay_sel_det,
    input  logic                    i2c_sda_in,
    output soc_bus_pkg::gpio_out_t  gpio,
    output soc_bus_pkg::bus_data_t  gpio_rdata
);

    import soc_bus_pkg::*;

    logic [3:0] reg_idx;
    logic       is_write;

    assign reg_idx  = req.addr[5:2];
    assign is_write = (req.strb != '0);

    // ----------------------------------------------------------------------
    // Control registers
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            gpio.delay_sel  <= delay_sel_det;        // Start from the detected tap
            gpio.led_red    <= `GPIO_RST_LED;
            gpio.led_green  <= `GPIO_RST_LED;
            gpio.led_blue   <= `GPIO_RST_LED;
            gpio.z80_rst    <= `GPIO_RST_Z80_RST;
            gpio.i2c_scl    <= `GPIO_RST_I2C_SCL;
            gpio.i2c_sda_oe <= `GPIO_RST_I2C_SDA_OE;
            gpio.usb_rstn   <= `GPIO_RST_USB_RSTN;
        end else if (gpio_acc && is_write) begin
            case (reg_idx)
                `GPIO_REG_DELAY: gpio.delay_sel <= req.wdata[4:0];
                `GPIO_REG_LED: begin
                    gpio.led_red   <= req.wdata[0];
                    gpio.led_green <= req.wdata[1];
                    gpio.led_blue  <= req.wdata[2];
                end
                `GPIO_REG_Z80_RST: gpio.z80_rst  <= req.wdata[0];
                `GPIO_REG_I2C_SCL: gpio.i2c_scl  <= req.wdata[0];
                // Open drain, a written 1 releases the line
                `GPIO_REG_I2C_SDA: gpio.i2c_sda_oe <= !req.wdata[0];
                `GPIO_REG_USB_RST: gpio.usb_rstn <= req.wdata[0];
                default: ;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Read-back
    // ----------------------------------------------------------------------

    // Indices without read-back leave the last word in place
    always_ff @(posedge clk_rv) begin
        if (gpio_acc && !is_write) begin
            case (reg_idx)
                `GPIO_REG_DELAY: begin
                    gpio_rdata <= {27'd0, delay_sel_det};
                end
                `GPIO_REG_LED: begin
                    gpio_rdata <= {29'd0, gpio.led_blue, gpio.led_green, gpio.led_red};
                end
                `GPIO_REG_Z80_RST: begin
                    gpio_rdata <= {31'd0, gpio.z80_rst};
                end
                `GPIO_REG_I2C_SDA: begin
                    gpio_rdata <= {31'd0, i2c_sda_in};   // Live pin level
                end
                default: ;
            endcase
        end
    end

endmodule

// File: logic/bus_response.sv
`include "soc_bus_settings.svh"

module bus_response (
    input  logic                     clk_rv,
    input  logic                     rst_rv,
    input  soc_bus_pkg::region_sel_t sel,
    input  soc_bus_pkg::access_t     acc,
    input  soc_bus_pkg::bus_data_t   ram_rdata,
    input  soc_bus_pkg::bus_data_t   gpio_rdata,
    output logic                     ready,
    output soc_bus_pkg::bus_data_t   rdata,
    output logic                     bus_error
);

    import soc_bus_pkg::*;

    // Every region answers after one cycle, unmapped ones too
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            ready <= 1'b0;
        end else begin
            ready <= acc.pending;         // Pending drops once ready is seen
        end
    end

    // Sticky until reset
    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            bus_error <= 1'b0;
        end else if (acc.bad_access) begin
            bus_error <= 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // Read data select
    // ----------------------------------------------------------------------

    always_comb begin
        if (sel.ram) begin
            rdata = ram_rdata;
        end else if (sel.gpio) begin
            rdata = gpio_rdata;
        end else begin
            rdata = `BUS_UNMAPPED_DATA;   // Video RAM has no read path either
        end
    end

endmodule

// File: logic/soc_bus_top.sv
module soc_bus_top (
    input  logic                    clk_rv,
    input  logic                    rst_rv,
    input  soc_bus_pkg::bus_req_t   req,
    input  soc_bus_pkg::bus_addr_t  la_addr,
    output logic                    ready,
    output soc_bus_pkg::bus_data_t  rdata,
    output logic                    bus_error,
    input  soc_bus_pkg::delay_sel_t delay_sel_det,
    input  logic                    i2c_sda_in,
    output soc_bus_pkg::gpio_out_t  gpio,
    output soc_bus_pkg::vram_wr_t   vram_wr
);

    import soc_bus_pkg::*;

    region_sel_t sel;
    access_t     acc;
    bus_data_t   ram_rdata;
    bus_data_t   gpio_rdata;

    // ----------------------------------------------------------------------
    // Decode stage
    // ----------------------------------------------------------------------

    bus_region_decode u_decode (
        .clk_rv  (clk_rv),
        .rst_rv  (rst_rv),
        .la_addr (la_addr),
        .req     (req),
        .ready   (ready),             // Fed back to close the access
        .sel     (sel),
        .acc     (acc)
    );

    // ----------------------------------------------------------------------
    // Execute stage
    // ----------------------------------------------------------------------

    onchip_mem_targets u_mem (
        .clk_rv    (clk_rv),
        .req       (req),
        .acc       (acc),
        .ram_rdata (ram_rdata),
        .vram_wr   (vram_wr)
    );

    gpio_regs u_gpio (
        .clk_rv        (clk_rv),
        .rst_rv        (rst_rv),
        .req           (req),
        .gpio_acc      (acc.gpio_acc),
        .delay_sel_det (delay_sel_det),
        .i2c_sda_in    (i2c_sda_in),
        .gpio          (gpio),
        .gpio_rdata    (gpio_rdata)
    );

    // Result stage
    bus_response u_resp (
        .clk_rv     (clk_rv),
        .rst_rv     (rst_rv),
        .sel        (sel),
        .acc        (acc),
        .ram_rdata  (ram_rdata),
        .gpio_rdata (gpio_rdata),
        .ready      (ready),
        .rdata      (rdata),
        .bus_error  (bus_error)
    );

endmodule

// File: dv/tb_soc_bus.sv
`include "soc_bus_settings.svh"

module tb_soc_bus;

    import soc_bus_pkg::*;

    localparam int CLK_HALF  = 20;
    localparam int DRIVE_DLY = 2;     // Drive and sample point after the rising edge
    localparam int MAX_WAIT  = 4;

    // One line of the data file
    typedef struct packed {
        int          op;              // 0 bus access, 1 reset
        int          test;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] strb;
        logic [31:0] dly;
        logic [31:0] sda;
        logic [31:0] exp_rdata;
        logic [31:0] exp_gpio;
        logic [31:0] exp_err;
    } vector_t;

    logic        clk_rv;
    logic        rst_rv;
    bus_req_t    req;
    bus_addr_t   la_addr;
    logic        ready;
    bus_data_t   rdata;
    logic        bus_error;
    delay_sel_t  delay_sel_det;
    logic        i2c_sda_in;
    gpio_out_t   gpio;
    vram_wr_t    vram_wr;

    vector_t     vecs[$];
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          error_count = 0;
    int          test_errors = 0;
    int          tests_run   = 0;

    soc_bus_top u_soc_bus_top (
        .clk_rv        (clk_rv),
        .rst_rv        (rst_rv),
        .req           (req),
        .la_addr       (la_addr),
        .ready         (ready),
        .rdata         (rdata),
        .bus_error     (bus_error),
        .delay_sel_det (delay_sel_det),
        .i2c_sda_in    (i2c_sda_in),
        .gpio          (gpio),
        .vram_wr       (vram_wr)
    );

    always #CLK_HALF clk_rv = ~clk_rv;

    // Ends a run that stops making progress
    always @(posedge clk_rv) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------

    task automatic log_mismatch(input string msg);
        $display("** Error at time %0t: %s", $time, msg);
        test_errors++;
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        vector_t     v;
        fd = $fopen("dv/soc_bus_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the data file dv/soc_bus_testdata.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%d %d %h %h %h %h %h %h %h %h", v.op, v.test, v.addr,
                            v.wdata, v.strb, v.dly, v.sda, v.exp_rdata, v.exp_gpio, v.exp_err);
                if (n == 10) begin
                    vecs.push_back(v);    // Comment and blank lines scan no fields
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_reset(input delay_sel_t dly, input logic sda);
        rst_rv        = 1'b0;
        req           = '0;
        delay_sel_det = dly;
        i2c_sda_in    = sda;
        repeat (2) @(posedge clk_rv);
        #DRIVE_DLY;
        rst_rv = 1'b1;
    endtask

    task automatic check_reset_state(input vector_t v);
        apply_reset(v.dly[4:0], v.sda[0]);
        assert (gpio == v.exp_gpio[11:0])
            else log_mismatch($sformatf("gpio after reset %03h, expected %03h",
                                        gpio, v.exp_gpio[11:0]));
        assert (bus_error == v.exp_err[0]) else log_mismatch("bus_error set after reset");
        assert (!ready) else log_mismatch("ready high after reset");
        assert (!vram_wr.wr_en) else log_mismatch("vram_wr pulse after reset");
    endtask

    // One access as the CPU master makes it, la_addr one cycle ahead of valid
    task automatic run_access(input vector_t v);
        int          waited;
        logic        expect_pulse;
        vram_index_t exp_index;
        expect_pulse = (v.addr >= `VRAM_BASE) && (v.addr < `VRAM_LIMIT) && (v.strb != 0);
        exp_index    = v.addr[13:2];
        la_addr       = v.addr;
        delay_sel_det = v.dly[4:0];
        i2c_sda_in    = v.sda[0];
        @(posedge clk_rv);
        #DRIVE_DLY;
        req.valid = 1'b1;
        req.addr  = v.addr;
        req.wdata = v.wdata;
        req.strb  = v.strb[3:0];
        waited = 0;
        do begin
            @(posedge clk_rv);
            #DRIVE_DLY;
            waited++;
        end while (!ready && waited < MAX_WAIT);
        assert (waited == 1)
            else log_mismatch($sformatf("ready after %0d cycles, expected 1", waited));
        if (v.strb == 0) begin
            assert (rdata == v.exp_rdata)
                else log_mismatch($sformatf("rdata %08h at %08h, expected %08h",
                                            rdata, v.addr, v.exp_rdata));
        end
        assert (gpio == v.exp_gpio[11:0])
            else log_mismatch($sformatf("gpio %03h, expected %03h", gpio, v.exp_gpio[11:0]));
        assert (bus_error == v.exp_err[0])
            else log_mismatch($sformatf("bus_error %0b, expected %0b", bus_error, v.exp_err[0]));
        assert (vram_wr.wr_en == expect_pulse)
            else log_mismatch($sformatf("vram_wr.wr_en %0b, expected %0b",
                                        vram_wr.wr_en, expect_pulse));
        if (expect_pulse) begin
            assert (vram_wr.index == exp_index && vram_wr.char_data == v.wdata[7:0])
                else log_mismatch($sformatf("vram_wr index %03h char %02h, expected %03h %02h",
                                            vram_wr.index, vram_wr.char_data,
                                            exp_index, v.wdata[7:0]));
        end
        @(posedge clk_rv);
        #DRIVE_DLY;
        req.valid = 1'b0;                 // Ready seen, access closes
        assert (!ready) else log_mismatch("ready stayed high for a second cycle");
        assert (!vram_wr.wr_en) else log_mismatch("vram_wr pulse longer than one cycle");
    endtask

    task automatic close_test(input int test);
        tests_run++;
        error_count += test_errors;
        if (test_errors == 0) begin
            $display("Test %0d: ok", test);
        end else begin
            $display("Test %0d: %0d check(s) failed", test, test_errors);
        end
        test_errors = 0;
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------

    initial begin
        int cur_test;
        clk_rv        = 1'b0;
        rst_rv        = 1'b0;
        req           = '0;
        la_addr       = '0;
        delay_sel_det = '0;
        i2c_sda_in    = 1'b1;
        load_vectors();
        cycle_limit = 10 * vecs.size() + 20;
        apply_reset(5'd0, 1'b1);
        cur_test = -1;
        foreach (vecs[i]) begin
            if (vecs[i].test != cur_test) begin
                if (cur_test >= 0) close_test(cur_test);
                cur_test = vecs[i].test;
            end
            if (vecs[i].op == 1) check_reset_state(vecs[i]);
            else run_access(vecs[i]);
        end
        if (cur_test >= 0) begin
            close_test(cur_test);
        end else begin
            $display("No test vectors were read, nothing was checked");
            error_count++;
        end
        $display("Tests run: %0d, failed checks: %0d", tests_run, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: dv/soc_bus_testdata.txt
// op(1 = reset) test addr wdata strb dly sda exp_rdata exp_gpio exp_err, all but op/test hex
// exp_rdata is compared on reads only (strb 0)
1 1 00000000 00000000 0 0A 1 00000000 50C 0
0 2 FFFF0010 12345678 F 0A 1 00000000 50C 0
0 2 FFFF0010 00000000 0 0A 1 12345678 50C 0
0 2 FFFF0010 000000AB 1 0A 1 00000000 50C 0
0 2 FFFF0010 00EF0000 4 0A 1 00000000 50C 0
0 2 FFFF0010 00000000 0 0A 1 12EF56AB 50C 0
0 2 FFFF2010 00000000 0 0A 1 12EF56AB 50C 0
0 3 03000004 00000005 F 0A 1 00000000 55C 0
0 3 0300000C 00000000 F 0A 1 00000000 554 0
0 3 03000014 00000000 F 0A 1 00000000 550 0
0 3 03000018 00000000 F 0A 1 00000000 552 0
0 3 0300001C 00000001 F 0A 1 00000000 553 0
0 3 03000000 00000000 0 15 1 00000015 553 0
0 3 03000004 00000000 0 0A 1 00000005 553 0
0 3 0300000C 00000000 0 0A 1 00000000 553 0
0 3 03000018 00000000 0 0A 1 00000001 553 0
0 3 03000018 00000000 0 0A 0 00000000 553 0
0 4 08000124 00000041 1 0A 1 00000000 553 0
0 4 08000124 00000000 0 0A 1 FFFFFFFF 553 0
0 5 80000000 00000000 0 0A 1 FFFFFFFF 553 1
0 5 FFFF0010 00000000 0 0A 1 12EF56AB 553 1
1 5 00000000 00000000 0 0A 1 00000000 50C 0
0 6 03000008 00000007 F 0A 1 00000000 50C 0
0 6 03000100 00000000 0 0A 1 FFFFFFFF 50C 1

// File: sources.f
+incdir+logic
logic/soc_bus_pkg.sv
logic/bus_region_decode.sv
logic/onchip_mem_targets.sv
logic/gpio_regs.sv
logic/bus_response.sv
logic/soc_bus_top.sv
dv/tb_soc_bus.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc_bus
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard logic/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(BUILD_DIR)
